// ==== vlog.f ====
source/local_ram_pkg.sv
source/sip1m9.sv
source/mem_ram_banks.sv
source/ras_cas_sequencer.sv
source/local_ram.sv
tests/local_ram_checker.sv
tests/tb_local_ram.sv

// ==== Makefile ====
# Verilator build and run of the local RAM testbench
TOP = tb_local_ram

.PHONY: build run clean

build:
	verilator --binary --timing --assert --top-module $(TOP) \
		-f vlog.f --Mdir obj_dir -o $(TOP)

# Sim output goes to sim.log; the fail message or a missing pass line fails the target
run: build
	./obj_dir/$(TOP) | tee sim.log
	! grep -q "TESTBENCH FAILED" sim.log
	grep -q "TESTBENCH PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== tests/tb_local_ram.sv ====
// Testbench for the local RAM with small chips (row_col_bits = 4)
// Directed tests then 200 LFSR requests; run is bounded by a cycle limit
`timescale 1ns/1ps

module tb_local_ram;

  localparam int row_col_bits   = 4;
  localparam int num_requests   = 235;
  localparam int timeout_cycles = num_requests * 6 + 40;

  logic                    sysclk;
  logic                    rst_n;
  logic                    req_valid;
  local_ram_pkg::ram_req_t req;
  logic                    rsp_valid;
  local_ram_pkg::ram_rsp_t rsp;
  int                      error_count;
  int                      checked_count;
  int                      sent_count    = 0;
  int                      test_count    = 0;
  int                      cycle_count   = 0;
  int                      start_errors  = 0;
  int                      start_checked = 0;
  int                      total_errors;
  logic [15:0]             lfsr;

  local_ram #(
    .row_col_bits(row_col_bits)
  ) local_ram_i (
    .sysclk   (sysclk),
    .rst_n    (rst_n),
    .req_valid(req_valid),
    .req      (req),
    .rsp_valid(rsp_valid),
    .rsp      (rsp)
  );

  local_ram_checker #(
    .row_col_bits(row_col_bits)
  ) checker_i (
    .sysclk       (sysclk),
    .rst_n        (rst_n),
    .req_valid    (req_valid),
    .req          (req),
    .rsp_valid    (rsp_valid),
    .rsp          (rsp),
    .error_count  (error_count),
    .checked_count(checked_count)
  );

  // 40 ns clock
  always #20 sysclk = ~sysclk;

  // Run limit
  always @(posedge sysclk) begin
    cycle_count++;
    if (cycle_count >= timeout_cycles) begin
      $display("timeout after %0d cycles, the run did not complete", cycle_count);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // One LFSR step per bit, first bit ends up as MSB
  task automatic take_bits(input int n, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < n; i++) begin
      lfsr  = lfsr_next(lfsr);
      value = {value[30:0], lfsr[0]};
    end
  endtask

  // Called on a falling edge; returns one idle cycle after the response
  task automatic send_request(input local_ram_pkg::bank_t bank,
                              input local_ram_pkg::word_addr_t addr,
                              input logic write, input local_ram_pkg::word_t data);
    req.bank  = bank;
    req.addr  = addr;
    req.write = write;
    req.wdata = data;
    req_valid = 1'b1;
    @(negedge sysclk);
    req_valid = 1'b0;
    while (!rsp_valid) begin
      @(negedge sysclk);
    end
    @(negedge sysclk);
    sent_count++;
  endtask

  task automatic finish_test(input string name);
    test_count++;
    $display("test %0d %s: %0d responses, %0d errors", test_count, name,
             checked_count - start_checked, error_count - start_errors);
    start_errors  = error_count;
    start_checked = checked_count;
  endtask

  task automatic random_traffic(input int count);
    logic [31:0] op;
    logic [31:0] bank_bits;
    logic [31:0] addr_bits;
    logic [31:0] data_bits;
    for (int i = 0; i < count; i++) begin
      take_bits(1, op);
      take_bits(2, bank_bits);
      take_bits(2 * row_col_bits, addr_bits);
      data_bits = '0;
      // Data bits only taken for writes
      if (op[0]) begin
        take_bits(18, data_bits);
      end
      send_request(bank_bits[1:0],
                   local_ram_pkg::word_addr_t'(addr_bits[2*row_col_bits-1:0]),
                   op[0], data_bits[17:0]);
    end
  endtask

  initial begin
    sysclk    = 1'b0;
    rst_n     = 1'b0;
    req_valid = 1'b0;
    req       = '0;
    lfsr      = 16'd15;
    repeat (16) @(negedge sysclk);
    rst_n = 1'b1;

    // Quiet bus, then an unwritten word in bank 0
    repeat (4) @(negedge sysclk);
    send_request(2'd0, 20'h00021, 1'b0, 18'h0);
    finish_test("unwritten read after reset");

    for (int b = 0; b < local_ram_pkg::num_banks; b++) begin
      for (int w = 0; w < 4; w++) begin
        send_request(local_ram_pkg::bank_t'(b), local_ram_pkg::word_addr_t'(w * 37 + 3),
                     1'b1, local_ram_pkg::word_t'((b << 12) ^ (w * 'h1111) ^ 'h2a5));
      end
      for (int w = 0; w < 4; w++) begin
        send_request(local_ram_pkg::bank_t'(b), local_ram_pkg::word_addr_t'(w * 37 + 3),
                     1'b0, 18'h0);
      end
    end
    finish_test("write then read, banks 0 to 2");

    // One address, three banks, three values
    send_request(2'd0, 20'h0005a, 1'b1, 18'h3a5a5);
    send_request(2'd1, 20'h0005a, 1'b1, 18'h05a5a);
    send_request(2'd2, 20'h0005a, 1'b1, 18'h2c3c3);
    send_request(2'd0, 20'h0005a, 1'b0, 18'h0);
    send_request(2'd1, 20'h0005a, 1'b0, 18'h0);
    send_request(2'd2, 20'h0005a, 1'b0, 18'h0);
    finish_test("bank isolation");

    send_request(2'd3, 20'h00010, 1'b1, 18'h3ffff);
    send_request(2'd3, 20'h00010, 1'b0, 18'h0);
    send_request(2'd3, 20'h000ff, 1'b1, 18'h12345);
    send_request(2'd3, 20'h000ff, 1'b0, 18'h0);
    finish_test("empty bank 3");

    random_traffic(200);
    finish_test("random traffic");

    total_errors = error_count;
    if (checked_count != sent_count) begin
      $display("only %0d of %0d requests got a checked response", checked_count, sent_count);
      total_errors++;
    end
    $display("%0d tests, %0d requests, %0d responses checked, %0d errors",
             test_count, sent_count, checked_count, total_errors);
    if (total_errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// ==== tests/local_ram_checker.sv ====
// Reference model of the local RAM, watching only the request and response ports
// Assumes one outstanding request; response expected exactly 4 cycles after it
`timescale 1ns/1ps

module local_ram_checker #(
  parameter int row_col_bits = 10
) (
  input  logic                    sysclk,
  input  logic                    rst_n,
  input  logic                    req_valid,
  input  local_ram_pkg::ram_req_t req,
  input  logic                    rsp_valid,
  input  local_ram_pkg::ram_rsp_t rsp,
  output int                      error_count,
  output int                      checked_count
);

  localparam int words   = 2 ** (2 * row_col_bits);
  localparam int latency = 4;

  // Shadow copy of the fitted banks
  local_ram_pkg::word_t shadow_data    [local_ram_pkg::num_banks][words];
  logic                 shadow_written [local_ram_pkg::num_banks][words];

  local_ram_pkg::ram_req_t pending_req;
  local_ram_pkg::ram_rsp_t pending_rsp;
  logic pending          = 1'b0;
  logic missing_reported = 1'b0;
  int   cycle            = 0;
  int   pending_cycle    = 0;
  int   errors           = 0;
  int   checked          = 0;

  assign error_count   = errors;
  assign checked_count = checked;

  initial begin
    for (int b = 0; b < local_ram_pkg::num_banks; b++) begin
      for (int w = 0; w < words; w++) begin
        shadow_data[b][w]    = '0;
        shadow_written[b][w] = 1'b0;
      end
    end
  end

  // Expected response from the shadow state before this request
  function automatic local_ram_pkg::ram_rsp_t expected_rsp(input local_ram_pkg::ram_req_t r);
    local_ram_pkg::ram_rsp_t   e;
    logic [2*row_col_bits-1:0] idx;
    e   = '0;
    idx = r.addr[2*row_col_bits-1:0];
    // Writes and bank 3 answer zero, no error
    if (!r.write && int'(r.bank) < local_ram_pkg::num_banks) begin
      if (shadow_written[r.bank][idx]) begin
        e.rdata = shadow_data[r.bank][idx];
      end else begin
        // Never written, power-up parity is wrong
        e.parity_err = 1'b1;
      end
    end
    return e;
  endfunction

  always @(posedge sysclk) begin
    cycle = cycle + 1;
    if (!rst_n) begin
      pending = 1'b0;
    end else begin
      if (rsp_valid && !pending) begin
        $display("response at cycle %0d without an outstanding request", cycle);
        errors++;
      end else if (rsp_valid) begin
        if (cycle - pending_cycle != latency) begin
          $display("mismatch rsp_valid latency: expected 'h%0h, got 'h%0h",
                   latency, cycle - pending_cycle);
          errors++;
        end
        if (rsp.rdata !== pending_rsp.rdata) begin
          $display("mismatch rsp.rdata (bank %0d addr 'h%05h): expected 'h%05h, got 'h%05h",
                   pending_req.bank, pending_req.addr, pending_rsp.rdata, rsp.rdata);
          errors++;
        end
        if (rsp.parity_err !== pending_rsp.parity_err) begin
          $display("mismatch rsp.parity_err (bank %0d addr 'h%05h): expected 'h%0h, got 'h%0h",
                   pending_req.bank, pending_req.addr, pending_rsp.parity_err, rsp.parity_err);
          errors++;
        end
        checked++;
        pending = 1'b0;
      end
      // Reported once per lost response
      if (pending && !missing_reported && cycle - pending_cycle > latency) begin
        $display("no response %0d cycles after the request at cycle %0d", latency, pending_cycle);
        missing_reported = 1'b1;
        errors++;
      end
      if (req_valid) begin
        if (pending) begin
          $display("request at cycle %0d while another is still outstanding", cycle);
          errors++;
        end
        pending_req = req;
        pending_rsp = expected_rsp(req);
        // Bank 3 writes are lost
        if (req.write && int'(req.bank) < local_ram_pkg::num_banks) begin
          shadow_data[req.bank][req.addr[2*row_col_bits-1:0]]    = req.wdata;
          shadow_written[req.bank][req.addr[2*row_col_bits-1:0]] = 1'b1;
        end
        pending          = 1'b1;
        missing_reported = 1'b0;
        pending_cycle    = cycle;
      end
    end
  end

endmodule

// ==== source/local_ram.sv ====
// Local RAM top, sequencer driving the three-bank array
// One outstanding request; rsp_valid follows req_valid by 4 cycles
`timescale 1ns/1ps

module local_ram #(
  parameter int row_col_bits = 10
) (
  input  logic                    sysclk,
  input  logic                    rst_n,
  input  logic                    req_valid,
  input  local_ram_pkg::ram_req_t req,
  output logic                    rsp_valid,
  output local_ram_pkg::ram_rsp_t rsp
);

  // Chip-side bus
  local_ram_pkg::row_col_t addr;
  local_ram_pkg::bank_t    bank;
  logic                    ras;
  logic                    cas;
  logic                    mwrite_n;
  local_ram_pkg::word_t    wdata;
  local_ram_pkg::word_t    rdata;
  logic                    corr_n;

  ras_cas_sequencer #(
    .row_col_bits(row_col_bits)
  ) sequencer_i (
    .sysclk   (sysclk),
    .rst_n    (rst_n),
    .req_valid(req_valid),
    .req      (req),
    .rdata    (rdata),
    .corr_n   (corr_n),
    .addr     (addr),
    .bank     (bank),
    .ras      (ras),
    .cas      (cas),
    .mwrite_n (mwrite_n),
    .wdata    (wdata),
    .rsp_valid(rsp_valid),
    .rsp      (rsp)
  );

  mem_ram_banks #(
    .row_col_bits(row_col_bits)
  ) banks_i (
    .sysclk  (sysclk),
    .rst_n   (rst_n),
    .addr    (addr),
    .bank    (bank),
    .ras     (ras),
    .cas     (cas),
    .mwrite_n(mwrite_n),
    .wdata   (wdata),
    .rdata   (rdata),
    .corr_n  (corr_n)
  );

endmodule

// ==== source/ras_cas_sequencer.sv ====
// RAS/CAS sequencer, one request at a time with no back-pressure
// Row is addr[2*row_col_bits-1:row_col_bits], column addr[row_col_bits-1:0]
// Response 4 cycles after the request strobe, reads and writes alike
`timescale 1ns/1ps

module ras_cas_sequencer #(
  parameter int row_col_bits = 10
) (
  input  logic                    sysclk,
  input  logic                    rst_n,
  input  logic                    req_valid,
  input  local_ram_pkg::ram_req_t req,
  input  local_ram_pkg::word_t    rdata,
  input  logic                    corr_n,
  output local_ram_pkg::row_col_t addr,
  output local_ram_pkg::bank_t    bank,
  output logic                    ras,
  output logic                    cas,
  output logic                    mwrite_n,
  output local_ram_pkg::word_t    wdata,
  output logic                    rsp_valid,
  output local_ram_pkg::ram_rsp_t rsp
);

  local_ram_pkg::seq_state_t state;
  local_ram_pkg::ram_req_t   req_q;
  local_ram_pkg::row_col_t   row_addr;
  local_ram_pkg::row_col_t   col_addr;

  // Row from the incoming request, column from the held one
  assign row_addr = local_ram_pkg::row_col_t'(req.addr[row_col_bits +: row_col_bits]);
  assign col_addr = local_ram_pkg::row_col_t'(req_q.addr[0 +: row_col_bits]);

  // Bank and write data follow the held request
  assign bank  = req_q.bank;
  assign wdata = req_q.wdata;

  // Control path
  always_ff @(posedge sysclk) begin
    if (!rst_n) begin
      state     <= local_ram_pkg::st_idle;
      ras       <= 1'b0;
      cas       <= 1'b0;
      mwrite_n  <= 1'b1;
      rsp_valid <= 1'b0;
    end else begin
      rsp_valid <= 1'b0;
      case (state)
        local_ram_pkg::st_idle: begin
          if (req_valid) begin
            ras   <= 1'b1;
            state <= local_ram_pkg::st_row;
          end
        end
        local_ram_pkg::st_row: begin
          // Column strobe, write enable for the early write
          cas      <= 1'b1;
          mwrite_n <= !req_q.write;
          state    <= local_ram_pkg::st_col;
        end
        local_ram_pkg::st_col: begin
          mwrite_n <= 1'b1;
          state    <= local_ram_pkg::st_data;
        end
        local_ram_pkg::st_data: begin
          ras       <= 1'b0;
          cas       <= 1'b0;
          rsp_valid <= 1'b1;
          state     <= local_ram_pkg::st_finish;
        end
        default: begin
          state <= local_ram_pkg::st_idle;
        end
      endcase
    end
  end

  // Request, address pins and response
  always_ff @(posedge sysclk) begin
    if (state == local_ram_pkg::st_idle && req_valid) begin
      req_q <= req;
      addr  <= row_addr;
    end
    if (state == local_ram_pkg::st_row) begin
      addr <= col_addr;
    end
    if (state == local_ram_pkg::st_data) begin
      // Writes answer with zero data, no error
      if (req_q.write) begin
        rsp <= '0;
      end else begin
        rsp.rdata      <= rdata;
        rsp.parity_err <= !corr_n;
      end
    end
  end

  // Requester waits for the previous response
  req_when_idle: assert property (@(posedge sysclk) disable iff (!rst_n)
    req_valid |-> state == local_ram_pkg::st_idle);

endmodule

// ==== source/mem_ram_banks.sv ====
// Three fitted banks of two SIP modules; bank number 3 selects nothing
// Read data is ORed over banks and parity errors ANDed into corr_n (active low)
`timescale 1ns/1ps

module mem_ram_banks #(
  parameter int row_col_bits = 10
) (
  input  logic                    sysclk,
  input  logic                    rst_n,
  input  local_ram_pkg::row_col_t addr,
  input  local_ram_pkg::bank_t    bank,
  input  logic                    ras,
  input  logic                    cas,
  input  logic                    mwrite_n,
  input  local_ram_pkg::word_t    wdata,
  output local_ram_pkg::word_t    rdata,
  output logic                    corr_n
);

  localparam int nb = local_ram_pkg::num_banks;

  logic [nb-1:0]   bank_sel;
  logic [nb-1:0]   ras_n_b;
  logic [nb-1:0]   cas_n_b;
  logic [2*nb-1:0] prd_n;

  // Per-bank outputs of the low and high chip
  local_ram_pkg::chip_data_t q_lo [nb];
  local_ram_pkg::chip_data_t q_hi [nb];

  for (genvar b = 0; b < nb; b++) begin : g_bank
    // Bank decode
    assign bank_sel[b] = (bank == local_ram_pkg::bank_t'(b));

    // Strobes gated by bank and active low at the chips
    assign ras_n_b[b] = ~(ras & bank_sel[b]);
    assign cas_n_b[b] = ~(cas & bank_sel[b]);

    // Bits 8:0
    sip1m9 #(
      .row_col_bits(row_col_bits)
    ) chip_lo (
      .sysclk (sysclk),
      .rst_n  (rst_n),
      .address(addr),
      .ras_n  (ras_n_b[b]),
      .cas_n  (cas_n_b[b]),
      .w_n    (mwrite_n),
      .d      (wdata[8:0]),
      .q      (q_lo[b]),
      .prd_n  (prd_n[2*b])
    );

    // Bits 17:9
    sip1m9 #(
      .row_col_bits(row_col_bits)
    ) chip_hi (
      .sysclk (sysclk),
      .rst_n  (rst_n),
      .address(addr),
      .ras_n  (ras_n_b[b]),
      .cas_n  (cas_n_b[b]),
      .w_n    (mwrite_n),
      .d      (wdata[17:9]),
      .q      (q_hi[b]),
      .prd_n  (prd_n[2*b+1])
    );
  end

  // Deselected chips drive zero
  always_comb begin
    rdata = '0;
    for (int i = 0; i < nb; i++) begin
      rdata = rdata | {q_hi[i], q_lo[i]};
    end
  end

  // Any chip with bad parity pulls it low
  assign corr_n = &prd_n;

  // Bank held through each RAS phase so only one bank opens per access
  one_bank_ras: assert property (@(posedge sysclk) disable iff (!rst_n)
    ras && $past(ras) |-> $stable(bank));

endmodule

// ==== source/sip1m9.sv ====
// Behavioural 1Mx9 SIP DRAM, no refresh and no real timing
// Only the low row_col_bits of the address pins are used
// Array powers up with data zero and parity one, so unwritten words flag an error
`timescale 1ns/1ps

module sip1m9 #(
  parameter int row_col_bits = 10
) (
  input  logic                     sysclk,
  input  logic                     rst_n,
  input  local_ram_pkg::row_col_t  address,
  input  logic                     ras_n,
  input  logic                     cas_n,
  input  logic                     w_n,
  input  local_ram_pkg::chip_data_t d,
  output local_ram_pkg::chip_data_t q,
  output logic                     prd_n
);

  localparam int depth = 2 ** (2 * row_col_bits);

  // Stored data and its parity bit
  local_ram_pkg::chip_data_t mem_data [depth];
  logic                      mem_par  [depth];

  logic [row_col_bits-1:0] row_q;
  logic [row_col_bits-1:0] col_q;
  logic                    ras_seen;
  logic                    cas_seen;
  logic                    row_edge;
  logic                    col_edge;
  local_ram_pkg::chip_data_t rd_data;
  logic                      rd_par;

  // Power-up contents
  initial begin
    for (int i = 0; i < depth; i++) begin
      mem_data[i] = '0;
      mem_par[i]  = 1'b1;
    end
  end

  // Strobe history, to find the first edge of each low phase
  always_ff @(posedge sysclk) begin
    if (!rst_n) begin
      ras_seen <= 1'b0;
      cas_seen <= 1'b0;
    end else begin
      ras_seen <= !ras_n;
      cas_seen <= !cas_n;
    end
  end

  assign row_edge = !ras_n && !ras_seen;
  assign col_edge = !cas_n && !cas_seen;

  // Row on RAS edge, column and early write on CAS edge
  always_ff @(posedge sysclk) begin
    if (row_edge) begin
      row_q <= address[row_col_bits-1:0];
    end
    if (col_edge) begin
      col_q <= address[row_col_bits-1:0];
    end
    if (col_edge && !w_n) begin
      mem_data[{row_q, address[row_col_bits-1:0]}] <= d;
      mem_par[{row_q, address[row_col_bits-1:0]}]  <= ^d;
    end
  end

  assign rd_data = mem_data[{row_q, col_q}];
  assign rd_par  = mem_par[{row_q, col_q}];

  // Zero when deselected so banks can be ORed
  assign q = cas_n ? '0 : rd_data;
  // Error only while CAS is active
  assign prd_n = cas_n || ((^rd_data) == rd_par);

  // Column strobe only inside an open row
  cas_inside_ras: assert property (@(posedge sysclk) disable iff (!rst_n)
    $fell(cas_n) |-> !ras_n);

endmodule

// ==== source/local_ram_pkg.sv ====
// Shared types for the local RAM and its testbench
// Fixed pin widths; row_col_bits selects how many address bits the chips use
package local_ram_pkg;

  // Fitted banks, bank 3 is the empty space
  localparam int num_banks = 3;

  // Memory bus word, two chips wide
  typedef logic [17:0] word_t;
  // Slice held by one SIP module, 8 data bits plus bit 8
  typedef logic [8:0] chip_data_t;
  // Multiplexed row/column pins
  typedef logic [9:0] row_col_t;
  typedef logic [1:0] bank_t;
  // Word address, row above column
  typedef logic [19:0] word_addr_t;

  typedef struct packed {
    bank_t      bank;
    word_addr_t addr;
    logic       write;
    word_t      wdata;
  } ram_req_t;

  typedef struct packed {
    word_t rdata;
    logic  parity_err;
  } ram_rsp_t;

  typedef enum logic [2:0] {
    st_idle,
    st_row,
    st_col,
    st_data,
    st_finish
  } seq_state_t;

endpackage
